// File: dispatchUnit.f
+incdir+src
src/dispatchPkg.sv
src/dispatchIf.sv
src/pipelineController.sv
src/issueQueueAllocator.sv
src/dispatchStage.sv
src/issueQueuePayload.sv
src/dispatchUnit.sv
tests/dispatchUnitTb.sv

// File: run.sh
#!/bin/sh
# Build and run the dispatch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f dispatchUnit.f --top-module dispatchUnitTb -o dispatchUnitSim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/dispatchUnitSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    exit 1
fi
exit 0

// File: src/dispatchIf.sv
//////////////////////////////////////////////////////////////////////
// Payload write bus
// Per-lane write strobe, pointer and entry from dispatch to the RAM
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "dispatchUnit_defs.svh"

interface dispatchIf;
    import dispatchPkg::*;

    logic write [`DISPATCH_WIDTH];
    IssueQueuePtr writePtr [`DISPATCH_WIDTH];
    IssueQueueEntry writeData [`DISPATCH_WIDTH];

    modport Stage (
        output write,
        output writePtr,
        output writeData
    );

    modport Ram (
        input write,
        input writePtr,
        input writeData
    );

endinterface

// File: src/dispatchPkg.sv
//////////////////////////////////////////////////////////////////////
// Dispatch types
// Vector types, controller states, the renamed op and the
// issue-queue payload entry with its sub-info layouts
//////////////////////////////////////////////////////////////////////

`include "dispatchUnit_defs.svh"

package dispatchPkg;

    typedef logic [`IQ_PTR_WIDTH-1:0] IssueQueuePtr;
    typedef logic [`PHY_REG_WIDTH-1:0] PhyRegNum;
    typedef logic [`AL_PTR_WIDTH-1:0] ActiveListPtr;
    typedef logic [31:0] Pc;
    typedef logic [1:0] MopType;

    // Flush recovery takes one extra cycle
    typedef enum logic {
        RUN,
        RECOVER
    } FlushState;

    // Op as it leaves rename
    typedef struct packed {
        logic valid;
        MopType mopType;
        logic operandTypeA;
        logic operandTypeB;
        PhyRegNum phySrcRegNumA;
        PhyRegNum phySrcRegNumB;
        logic writeReg;
        PhyRegNum phyDstRegNum;
        ActiveListPtr activeListPtr;
        Pc pc;
        logic [11:0] imm;
        logic [3:0] code;
        logic bPred;
    } RenamedOp;

    // Sub-info layouts, all SUB_INFO_WIDTH wide
    typedef struct packed {
        logic [3:0] aluCode;
        logic [11:0] imm;
    } IntSubInfo;

    typedef struct packed {
        logic [11:0] brDisp;
        logic bPred;
        logic [2:0] padding;
    } BrSubInfo;

    typedef struct packed {
        logic isStore;
        logic [1:0] accessSize;
        logic [11:0] offset;
        logic padding;
    } MemSubInfo;

    typedef struct packed {
        MopType mopType;
        logic srcRegValidA;
        logic srcRegValidB;
        PhyRegNum phySrcRegNumA;
        PhyRegNum phySrcRegNumB;
        logic writeReg;
        PhyRegNum phyDstRegNum;
        ActiveListPtr activeListPtr;
        Pc pc;
        logic [`SUB_INFO_WIDTH-1:0] subInfo;
    } IssueQueueEntry;

endpackage

// File: src/dispatchStage.sv
//////////////////////////////////////////////////////////////////////
// Dispatch stage
// Pipeline register per lane and formatting of issue-queue
// payload entries, including the op-type dependent sub-info
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "dispatchUnit_defs.svh"

module dispatchStage (
    input logic ctrl,
    input logic rstN,
    input logic stall,
    input logic clear,
    input dispatchPkg::RenamedOp inOp [`DISPATCH_WIDTH],
    input dispatchPkg::IssueQueuePtr allocPtr [`DISPATCH_WIDTH],
    dispatchIf.Stage payload,
    output logic dispatchValid [`DISPATCH_WIDTH],
    output dispatchPkg::IssueQueuePtr dispatchPtr [`DISPATCH_WIDTH]
);
    import dispatchPkg::*;

    RenamedOp opReg [`DISPATCH_WIDTH];
    IssueQueuePtr ptrReg [`DISPATCH_WIDTH];
    logic validReg [`DISPATCH_WIDTH];

    IntSubInfo intSub [`DISPATCH_WIDTH];
    BrSubInfo brSub [`DISPATCH_WIDTH];
    MemSubInfo memSub [`DISPATCH_WIDTH];
    IssueQueueEntry entry [`DISPATCH_WIDTH];
    logic update [`DISPATCH_WIDTH];

    // Pipeline register valids
    always_ff @(posedge ctrl) begin
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            if (!rstN || clear) begin
                validReg[i] <= 1'b0;
            end else if (!stall) begin
                validReg[i] <= inOp[i].valid;
            end
        end
    end

    // Op and its allocated pointer
    always_ff @(posedge ctrl) begin
        if (!stall) begin
            opReg <= inOp;
            ptrReg <= allocPtr;
        end
    end

    always_comb begin
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            update[i] = validReg[i] && !stall && !clear;

            intSub[i].aluCode = opReg[i].code;
            intSub[i].imm = opReg[i].imm;

            brSub[i].brDisp = opReg[i].imm;
            brSub[i].bPred = opReg[i].bPred;
            brSub[i].padding = '0;

            // Code field of a memory op: bit 3 store, bits 1:0 size
            memSub[i].isStore = opReg[i].code[3];
            memSub[i].accessSize = opReg[i].code[1:0];
            memSub[i].offset = opReg[i].imm;
            memSub[i].padding = 1'b0;

            entry[i].mopType = opReg[i].mopType;
            entry[i].srcRegValidA = (opReg[i].operandTypeA == `OOT_REG);
            entry[i].srcRegValidB = (opReg[i].operandTypeB == `OOT_REG);
            entry[i].phySrcRegNumA = opReg[i].phySrcRegNumA;
            entry[i].phySrcRegNumB = opReg[i].phySrcRegNumB;
            entry[i].writeReg = opReg[i].writeReg;
            entry[i].phyDstRegNum = opReg[i].phyDstRegNum;
            entry[i].activeListPtr = opReg[i].activeListPtr;
            entry[i].pc = opReg[i].pc;

            case (opReg[i].mopType)
                `MOP_BR: entry[i].subInfo = brSub[i];
                `MOP_MEM: entry[i].subInfo = memSub[i];
                default: entry[i].subInfo = intSub[i];
            endcase

            payload.write[i] = update[i];
            payload.writePtr[i] = ptrReg[i];
            payload.writeData[i] = entry[i];
            dispatchValid[i] = update[i];
            dispatchPtr[i] = ptrReg[i];
        end
    end

    // Allocator must never hand the same slot to two lanes
    for (genvar a = 0; a < `DISPATCH_WIDTH; a++) begin : gPtrCheckA
        for (genvar b = a + 1; b < `DISPATCH_WIDTH; b++) begin : gPtrCheckB
            assert property (@(posedge ctrl) disable iff (!rstN)
                update[a] && update[b] |-> ptrReg[a] != ptrReg[b])
                else $error("two lanes written to one issue-queue slot");
        end
    end

endmodule

// File: src/dispatchUnit.sv
//////////////////////////////////////////////////////////////////////
// Dispatch unit
// Two renamed ops per cycle into the issue-queue payload RAM
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "dispatchUnit_defs.svh"

module dispatchUnit (
    input logic ctrl,
    input logic rstN,
    input logic flush,
    input logic hold,
    input logic inValid [`DISPATCH_WIDTH],
    input dispatchPkg::MopType inMopType [`DISPATCH_WIDTH],
    input logic inOperandTypeA [`DISPATCH_WIDTH],
    input logic inOperandTypeB [`DISPATCH_WIDTH],
    input dispatchPkg::PhyRegNum inPhySrcA [`DISPATCH_WIDTH],
    input dispatchPkg::PhyRegNum inPhySrcB [`DISPATCH_WIDTH],
    input logic inWriteReg [`DISPATCH_WIDTH],
    input dispatchPkg::PhyRegNum inPhyDst [`DISPATCH_WIDTH],
    input dispatchPkg::ActiveListPtr inAlPtr [`DISPATCH_WIDTH],
    input dispatchPkg::Pc inPc [`DISPATCH_WIDTH],
    input logic [11:0] inImm [`DISPATCH_WIDTH],
    input logic [3:0] inCode [`DISPATCH_WIDTH],
    input logic inBPred [`DISPATCH_WIDTH],
    output logic ready,
    output logic dispatchValid [`DISPATCH_WIDTH],
    output dispatchPkg::IssueQueuePtr dispatchPtr [`DISPATCH_WIDTH],
    input dispatchPkg::IssueQueuePtr readPtr,
    output dispatchPkg::IssueQueueEntry readEntry,
    output logic readValid,
    input logic releaseEn,
    input dispatchPkg::IssueQueuePtr releasePtr
);
    import dispatchPkg::*;

    RenamedOp inOp [`DISPATCH_WIDTH];
    IssueQueuePtr allocPtr [`DISPATCH_WIDTH];
    logic [`IQ_PTR_WIDTH:0] freeCount;
    logic stall;
    logic clear;

    dispatchIf payloadBus ();

    // Gather the per-lane input fields into one op
    always_comb begin
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            inOp[i].valid = inValid[i];
            inOp[i].mopType = inMopType[i];
            inOp[i].operandTypeA = inOperandTypeA[i];
            inOp[i].operandTypeB = inOperandTypeB[i];
            inOp[i].phySrcRegNumA = inPhySrcA[i];
            inOp[i].phySrcRegNumB = inPhySrcB[i];
            inOp[i].writeReg = inWriteReg[i];
            inOp[i].phyDstRegNum = inPhyDst[i];
            inOp[i].activeListPtr = inAlPtr[i];
            inOp[i].pc = inPc[i];
            inOp[i].imm = inImm[i];
            inOp[i].code = inCode[i];
            inOp[i].bPred = inBPred[i];
        end
    end

    assign ready = !stall;

    pipelineController controller (
        .ctrl(ctrl), .rstN(rstN), .flush(flush), .hold(hold),
        .laneValid(inValid), .freeCount(freeCount),
        .stall(stall), .clear(clear)
    );

    issueQueueAllocator allocator (
        .ctrl(ctrl), .rstN(rstN), .stall(stall), .clear(clear),
        .laneValid(inValid), .allocPtr(allocPtr), .freeCount(freeCount),
        .releaseEn(releaseEn), .releasePtr(releasePtr)
    );

    dispatchStage stage (
        .ctrl(ctrl), .rstN(rstN), .stall(stall), .clear(clear),
        .inOp(inOp), .allocPtr(allocPtr), .payload(payloadBus.Stage),
        .dispatchValid(dispatchValid), .dispatchPtr(dispatchPtr)
    );

    issueQueuePayload payloadRam (
        .ctrl(ctrl), .rstN(rstN), .clear(clear), .payload(payloadBus.Ram),
        .readPtr(readPtr), .readEntry(readEntry), .readValid(readValid),
        .releaseEn(releaseEn), .releasePtr(releasePtr)
    );

endmodule

// File: src/dispatchUnit_defs.svh
//////////////////////////////////////////////////////////////////////
// Dispatch subsystem definitions
// Lane count, issue queue geometry, register widths and the
// op-type and operand-type codes
//////////////////////////////////////////////////////////////////////

`ifndef DISPATCH_UNIT_DEFS_SVH
`define DISPATCH_UNIT_DEFS_SVH

// Lanes and issue queue
`define DISPATCH_WIDTH 2
`define IQ_DEPTH 8
`define IQ_PTR_WIDTH 3

// Register and pointer widths
`define PHY_REG_WIDTH 6
`define AL_PTR_WIDTH 5
`define SUB_INFO_WIDTH 16

// Op-type codes
`define MOP_INT 2'd0
`define MOP_BR 2'd1
`define MOP_MEM 2'd2

// Operand types
`define OOT_REG 1'b1
`define OOT_IMM 1'b0

`endif

// File: src/issueQueueAllocator.sv
//////////////////////////////////////////////////////////////////////
// Issue queue allocator
// Circular free list of issue-queue pointers, two pops and one
// push per cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "dispatchUnit_defs.svh"

module issueQueueAllocator (
    input logic ctrl,
    input logic rstN,
    input logic stall,
    input logic clear,
    input logic laneValid [`DISPATCH_WIDTH],
    output dispatchPkg::IssueQueuePtr allocPtr [`DISPATCH_WIDTH],
    output logic [`IQ_PTR_WIDTH:0] freeCount,
    input logic releaseEn,
    input dispatchPkg::IssueQueuePtr releasePtr
);
    import dispatchPkg::*;

    IssueQueuePtr freeList [`IQ_DEPTH];
    IssueQueuePtr head;
    IssueQueuePtr tail;
    logic [`IQ_PTR_WIDTH:0] count;
    logic [`IQ_PTR_WIDTH:0] popCount;
    logic [`IQ_PTR_WIDTH:0] popTaken;
    logic push;

    // Lanes take pointers in order, skipping invalid lanes
    always_comb begin
        popCount = '0;
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            allocPtr[i] = freeList[head + popCount[`IQ_PTR_WIDTH-1:0]];
            if (laneValid[i]) begin
                popCount = popCount + 1'b1;
            end
        end
        popTaken = stall ? '0 : popCount;
        push = releaseEn && !clear;
    end

    always_ff @(posedge ctrl) begin
        if (!rstN || clear) begin
            // Back to full, pointers in ascending order
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                freeList[i] <= IssueQueuePtr'(i);
            end
            head <= '0;
            tail <= '0;
            count <= (`IQ_PTR_WIDTH + 1)'(`IQ_DEPTH);
        end else begin
            head <= head + popTaken[`IQ_PTR_WIDTH-1:0];
            if (push) begin
                freeList[tail] <= releasePtr;
                tail <= tail + 1'b1;
            end
            count <= count - popTaken + (`IQ_PTR_WIDTH + 1)'(push);
        end
    end

    assign freeCount = count;

    // The controller must stall before the list runs dry
    assert property (@(posedge ctrl) disable iff (!rstN || clear) popTaken <= count)
        else $error("free list popped beyond its count");

    assert property (@(posedge ctrl) disable iff (!rstN)
        push |-> count != (`IQ_PTR_WIDTH + 1)'(`IQ_DEPTH))
        else $error("pointer released into a full free list");

endmodule

// File: src/issueQueuePayload.sv
//////////////////////////////////////////////////////////////////////
// Issue queue payload RAM
// Entries with valid bits, two-lane write, combinational read and
// release by pointer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "dispatchUnit_defs.svh"

module issueQueuePayload (
    input logic ctrl,
    input logic rstN,
    input logic clear,
    dispatchIf.Ram payload,
    input dispatchPkg::IssueQueuePtr readPtr,
    output dispatchPkg::IssueQueueEntry readEntry,
    output logic readValid,
    input logic releaseEn,
    input dispatchPkg::IssueQueuePtr releasePtr
);
    import dispatchPkg::*;

    IssueQueueEntry ram [`IQ_DEPTH];
    logic [`IQ_DEPTH-1:0] entryValid;

    always_ff @(posedge ctrl) begin
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            if (payload.write[i]) begin
                ram[payload.writePtr[i]] <= payload.writeData[i];
            end
        end
    end

    always_ff @(posedge ctrl) begin
        if (!rstN || clear) begin
            entryValid <= '0;
        end else begin
            for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
                if (payload.write[i]) begin
                    entryValid[payload.writePtr[i]] <= 1'b1;
                end
            end
            // Slot goes back to the free list at the same edge
            if (releaseEn) begin
                entryValid[releasePtr] <= 1'b0;
            end
        end
    end

    assign readEntry = ram[readPtr];
    assign readValid = entryValid[readPtr];

    // A slot is only handed out again once it has been released
    for (genvar i = 0; i < `DISPATCH_WIDTH; i++) begin : gOverwriteCheck
        assert property (@(posedge ctrl) disable iff (!rstN)
            payload.write[i] |-> !entryValid[payload.writePtr[i]])
            else $error("write to an issue-queue entry that is still valid");
    end

endmodule

// File: src/pipelineController.sv
//////////////////////////////////////////////////////////////////////
// Pipeline controller
// Flush recovery FSM and stage-wide stall and clear
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "dispatchUnit_defs.svh"

module pipelineController (
    input logic ctrl,
    input logic rstN,
    input logic flush,
    input logic hold,
    input logic laneValid [`DISPATCH_WIDTH],
    input logic [`IQ_PTR_WIDTH:0] freeCount,
    output logic stall,
    output logic clear
);
    import dispatchPkg::*;

    FlushState state;
    logic [`IQ_PTR_WIDTH:0] needCount;

    // A flush always leaves one recovery cycle behind it
    always_ff @(posedge ctrl) begin
        if (!rstN) begin
            state <= RUN;
        end else if (flush) begin
            state <= RECOVER;
        end else begin
            state <= RUN;
        end
    end

    always_comb begin
        needCount = '0;
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            if (laneValid[i]) begin
                needCount = needCount + 1'b1;
            end
        end
        clear = flush || (state == RECOVER);
        // Not enough free slots for this cycle's ops
        stall = hold || clear || (freeCount < needCount);
    end

    assert property (@(posedge ctrl) disable iff (!rstN) clear |-> stall)
        else $error("clear without stall");

endmodule

// File: tests/dispatchUnitTb.sv
//////////////////////////////////////////////////////////////////////
// Dispatch unit testbench
// Drives renamed ops, mirrors the free list and payload table,
// and checks the DUT with concurrent assertions
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "dispatchUnit_defs.svh"

module dispatchUnitTb;
    import dispatchPkg::*;

    // Stimulus runs about 80 cycles, limit leaves a wide margin
    localparam int TIMEOUT_CYCLES = 400;

    logic ctrl;
    logic rstN;
    logic flush;
    logic hold;
    logic inValid [`DISPATCH_WIDTH];
    MopType inMopType [`DISPATCH_WIDTH];
    logic inOperandTypeA [`DISPATCH_WIDTH];
    logic inOperandTypeB [`DISPATCH_WIDTH];
    PhyRegNum inPhySrcA [`DISPATCH_WIDTH];
    PhyRegNum inPhySrcB [`DISPATCH_WIDTH];
    logic inWriteReg [`DISPATCH_WIDTH];
    PhyRegNum inPhyDst [`DISPATCH_WIDTH];
    ActiveListPtr inAlPtr [`DISPATCH_WIDTH];
    Pc inPc [`DISPATCH_WIDTH];
    logic [11:0] inImm [`DISPATCH_WIDTH];
    logic [3:0] inCode [`DISPATCH_WIDTH];
    logic inBPred [`DISPATCH_WIDTH];
    logic ready;
    logic dispatchValid [`DISPATCH_WIDTH];
    IssueQueuePtr dispatchPtr [`DISPATCH_WIDTH];
    IssueQueuePtr readPtr;
    IssueQueueEntry readEntry;
    logic readValid;
    logic releaseEn;
    IssueQueuePtr releasePtr;

    // Reference model state
    IssueQueuePtr freeQ [$];
    int freeNum;
    logic recovering;
    logic stageValid [`DISPATCH_WIDTH];
    IssueQueuePtr stagePtr [`DISPATCH_WIDTH];
    IssueQueueEntry stageEntry [`DISPATCH_WIDTH];
    IssueQueueEntry expEntry [`IQ_DEPTH];
    logic expValid [`IQ_DEPTH];
    IssueQueueEntry expRead;
    logic expReadValid;
    logic expReady;

    int errors = 0;
    int opsWritten = 0;
    int cycles;
    int seed = 32'h76d4_b88c;

    dispatchUnit DUT (
        .ctrl(ctrl), .rstN(rstN), .flush(flush), .hold(hold),
        .inValid(inValid), .inMopType(inMopType),
        .inOperandTypeA(inOperandTypeA), .inOperandTypeB(inOperandTypeB),
        .inPhySrcA(inPhySrcA), .inPhySrcB(inPhySrcB), .inWriteReg(inWriteReg),
        .inPhyDst(inPhyDst), .inAlPtr(inAlPtr), .inPc(inPc), .inImm(inImm),
        .inCode(inCode), .inBPred(inBPred), .ready(ready),
        .dispatchValid(dispatchValid), .dispatchPtr(dispatchPtr),
        .readPtr(readPtr), .readEntry(readEntry), .readValid(readValid),
        .releaseEn(releaseEn), .releasePtr(releasePtr)
    );

    initial begin
        ctrl = 1'b0;
        forever #50 ctrl = ~ctrl;
    end

    task automatic logMismatch(input string name,
                               input logic [$bits(IssueQueueEntry)-1:0] expected,
                               input logic [$bits(IssueQueueEntry)-1:0] actual);
        errors++;
        $display("FAIL %s expected %h actual %h", name, expected, actual);
    endtask

    // Expected payload entry built from a lane's current inputs
    function automatic IssueQueueEntry formatEntry(input int lane);
        IssueQueueEntry e;
        e.mopType = inMopType[lane];
        e.srcRegValidA = (inOperandTypeA[lane] == `OOT_REG);
        e.srcRegValidB = (inOperandTypeB[lane] == `OOT_REG);
        e.phySrcRegNumA = inPhySrcA[lane];
        e.phySrcRegNumB = inPhySrcB[lane];
        e.writeReg = inWriteReg[lane];
        e.phyDstRegNum = inPhyDst[lane];
        e.activeListPtr = inAlPtr[lane];
        e.pc = inPc[lane];
        case (inMopType[lane])
            `MOP_BR: e.subInfo = {inImm[lane], inBPred[lane], 3'b000};
            `MOP_MEM: e.subInfo = {inCode[lane][3], inCode[lane][1:0], inImm[lane], 1'b0};
            default: e.subInfo = {inCode[lane], inImm[lane]};
        endcase
        return e;
    endfunction

    // Model steps on the same edge as the DUT, from pre-edge values
    always @(posedge ctrl) begin
        if (!rstN || flush || recovering) begin
            freeQ.delete();
            for (int p = 0; p < `IQ_DEPTH; p++) begin
                freeQ.push_back(IssueQueuePtr'(p));
                expValid[p] = 1'b0;
            end
            for (int l = 0; l < `DISPATCH_WIDTH; l++) begin
                stageValid[l] = 1'b0;
            end
            recovering = rstN && flush;
        end else begin
            for (int l = 0; l < `DISPATCH_WIDTH; l++) begin
                if (dispatchValid[l]) begin
                    expEntry[dispatchPtr[l]] = stageEntry[l];
                    expValid[dispatchPtr[l]] = 1'b1;
                    opsWritten++;
                end
            end
            // Lanes take free pointers in lane order
            if (expReady) begin
                for (int l = 0; l < `DISPATCH_WIDTH; l++) begin
                    stageValid[l] = inValid[l];
                    if (inValid[l]) begin
                        stagePtr[l] = freeQ.pop_front();
                        stageEntry[l] = formatEntry(l);
                    end
                end
            end
            if (releaseEn) begin
                expValid[releasePtr] = 1'b0;
                freeQ.push_back(releasePtr);
            end
        end
        freeNum = freeQ.size();
    end

    always_comb begin
        expRead = expEntry[readPtr];
        expReadValid = expValid[readPtr];
        expReady = !(hold || flush || recovering ||
                     freeNum < (int'(inValid[0]) + int'(inValid[1])));
    end

    // Checks sample mid-cycle, where DUT and model are both settled
    assert property (@(negedge ctrl) disable iff (!rstN) ready == expReady)
        else logMismatch("readyLevel", expReady, ready);

    assert property (@(negedge ctrl) disable iff (!rstN)
        !ready |-> !dispatchValid[0] && !dispatchValid[1])
        else logMismatch("stallNoWrite", 0, {dispatchValid[0], dispatchValid[1]});

    assert property (@(negedge ctrl) disable iff (!rstN)
        dispatchValid[0] && dispatchValid[1] |-> dispatchPtr[0] != dispatchPtr[1])
        else logMismatch("ptrUnique", dispatchPtr[0], dispatchPtr[1]);

    assert property (@(negedge ctrl) disable iff (!rstN) readValid == expReadValid)
        else logMismatch("readValid", expReadValid, readValid);

    assert property (@(negedge ctrl) disable iff (!rstN)
        readValid && expReadValid && expRead.mopType != `MOP_MEM |-> readEntry == expRead)
        else logMismatch("intBrFormat", expRead, readEntry);

    assert property (@(negedge ctrl) disable iff (!rstN)
        readValid && expReadValid && expRead.mopType == `MOP_MEM |-> readEntry == expRead)
        else logMismatch("memFormat", expRead, readEntry);

    assert property (@(negedge ctrl) disable iff (!rstN)
        readValid && expReadValid |->
        {readEntry.srcRegValidA, readEntry.srcRegValidB} ==
        {expRead.srcRegValidA, expRead.srcRegValidB})
        else logMismatch("srcReady", {expRead.srcRegValidA, expRead.srcRegValidB},
                         {readEntry.srcRegValidA, readEntry.srcRegValidB});

    for (genvar l = 0; l < `DISPATCH_WIDTH; l++) begin : gLaneCheck
        assert property (@(negedge ctrl) disable iff (!rstN)
            ready |-> dispatchValid[l] == stageValid[l])
            else logMismatch("writeEnable", stageValid[l], dispatchValid[l]);
        assert property (@(negedge ctrl) disable iff (!rstN)
            dispatchValid[l] |-> dispatchPtr[l] == stagePtr[l])
            else logMismatch("ptrOrder", stagePtr[l], dispatchPtr[l]);
        // Slot being written must not hold a live entry
        assert property (@(negedge ctrl) disable iff (!rstN)
            dispatchValid[l] |-> !expValid[dispatchPtr[l]])
            else logMismatch("ptrFree", 0, expValid[dispatchPtr[l]]);
    end

    task automatic nextCycle;
        @(posedge ctrl);
        #1;
    endtask

    task automatic clearLane(input int lane);
        inValid[lane] = 1'b0;
        inMopType[lane] = '0;
        inOperandTypeA[lane] = 1'b0;
        inOperandTypeB[lane] = 1'b0;
        inPhySrcA[lane] = '0;
        inPhySrcB[lane] = '0;
        inWriteReg[lane] = 1'b0;
        inPhyDst[lane] = '0;
        inAlPtr[lane] = '0;
        inPc[lane] = '0;
        inImm[lane] = '0;
        inCode[lane] = '0;
        inBPred[lane] = 1'b0;
    endtask

    task automatic driveLane(input int lane, input MopType mop);
        inValid[lane] = 1'b1;
        inMopType[lane] = mop;
        inOperandTypeA[lane] = 1'($random(seed));
        inOperandTypeB[lane] = 1'($random(seed));
        inPhySrcA[lane] = PhyRegNum'($random(seed));
        inPhySrcB[lane] = PhyRegNum'($random(seed));
        inWriteReg[lane] = 1'($random(seed));
        inPhyDst[lane] = PhyRegNum'($random(seed));
        inAlPtr[lane] = ActiveListPtr'($random(seed));
        inPc[lane] = $random(seed);
        inImm[lane] = 12'($random(seed));
        inCode[lane] = 4'($random(seed));
        inBPred[lane] = 1'($random(seed));
    endtask

    // Waits for the edge that accepts the driven lanes
    task automatic waitAccept;
        @(negedge ctrl);
        while (!ready) begin
            @(negedge ctrl);
        end
        @(posedge ctrl);
        #1;
        for (int l = 0; l < `DISPATCH_WIDTH; l++) begin
            inValid[l] = 1'b0;
        end
    endtask

    task automatic releaseSlot(input int slot);
        releaseEn = 1'b1;
        releasePtr = IssueQueuePtr'(slot);
        readPtr = IssueQueuePtr'(slot);
        nextCycle();
        releaseEn = 1'b0;
    endtask

    task automatic readSlot(input int slot);
        readPtr = IssueQueuePtr'(slot);
        nextCycle();
    endtask

    task automatic readAll;
        for (int p = 0; p < `IQ_DEPTH; p++) begin
            readSlot(p);
        end
    endtask

    initial begin : stimulus
        for (int l = 0; l < `DISPATCH_WIDTH; l++) begin
            clearLane(l);
        end
        flush = 1'b0;
        hold = 1'b0;
        readPtr = '0;
        releaseEn = 1'b0;
        releasePtr = '0;
        rstN = 1'b0;
        repeat (10) @(posedge ctrl);
        #1;
        rstN = 1'b1;

        // Fill all eight slots with mixed op types
        for (int k = 0; k < 4; k++) begin
            driveLane(0, MopType'((2 * k) % 3));
            driveLane(1, MopType'((2 * k + 1) % 3));
            waitAccept();
        end
        nextCycle();
        readAll();

        // Queue full, lane 0 waits until a slot comes back
        driveLane(0, `MOP_INT);
        repeat (3) nextCycle();
        releaseSlot(3);
        waitAccept();
        nextCycle();
        readSlot(3);

        // Op held in the pipeline register
        releaseSlot(5);
        releaseSlot(0);
        driveLane(0, `MOP_BR);
        driveLane(1, `MOP_MEM);
        waitAccept();
        hold = 1'b1;
        repeat (3) nextCycle();
        hold = 1'b0;
        nextCycle();
        readSlot(5);
        readSlot(0);

        // Flush with an op in flight
        releaseSlot(6);
        driveLane(1, `MOP_INT);
        waitAccept();
        flush = 1'b1;
        nextCycle();
        flush = 1'b0;
        nextCycle();
        readAll();
        driveLane(0, `MOP_MEM);
        driveLane(1, `MOP_BR);
        waitAccept();
        nextCycle();
        readSlot(0);
        readSlot(1);

        // Random types, code 3 included
        for (int k = 0; k < 3; k++) begin
            driveLane(0, MopType'($random(seed)));
            if (k == 0) begin
                driveLane(1, MopType'(3));
            end else begin
                driveLane(1, MopType'($random(seed)));
            end
            waitAccept();
        end
        nextCycle();
        readAll();
        nextCycle();

        $display("Summary: %0d errors, %0d ops written", errors, opsWritten);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge ctrl);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule
